// ==== flist.f ====
+incdir+hw
+incdir+tb
hw/aes_types_pkg.sv
hw/apb_regs_pkg.sv
hw/aes_sbox.sv
hw/subbytes_block.sv
hw/mixcolumns_block.sv
hw/key_expansion_block.sv
hw/round_block_sequential.sv
hw/aes_cipher_engine.sv
hw/aes_apb_regs.sv
hw/aes_apb_top.sv
tb/aes_apb_tb.sv

// ==== tb/aes_model.svh ====
// AES-128 reference model: S-box from GF(2^8) inversion, key schedule and block encryption.
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1.
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            p = p ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// Inverse as a^254, so zero maps to zero.
function automatic logic [7:0] gf_inverse(input logic [7:0] a);
    logic [7:0] r;
    logic [7:0] sq;
    r  = 8'h01;
    sq = a;
    // Product of a^2, a^4 up to a^128.
    for (int i = 1; i < 8; i++) begin
        sq = gf_mul(sq, sq);
        r  = gf_mul(r, sq);
    end
    return r;
endfunction

function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
    logic [15:0] d;
    d = {b, b} << n;
    return d[15:8];
endfunction

// Inversion followed by the FIPS-197 affine map.
function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [7:0] v;
    v = gf_inverse(b);
    return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
endfunction

// Entries of the first MixColumns matrix row {2 3 1 1}.
function automatic logic [7:0] mix_coef(input int d);
    case (d)
        0:       return 8'h02;
        1:       return 8'h03;
        default: return 8'h01;
    endcase
endfunction

function automatic logic [127:0] next_round_key(input logic [127:0] key, input logic [7:0] rcon);
    logic [31:0] w [4];
    logic [31:0] t;
    for (int i = 0; i < 4; i++) begin
        w[i] = key[127-32*i -: 32];
    end
    // RotWord and SubWord of the last word.
    t = {sub_byte(w[3][23:16]), sub_byte(w[3][15:8]),
         sub_byte(w[3][7:0]), sub_byte(w[3][31:24])};
    t[31:24] = t[31:24] ^ rcon;
    w[0] = w[0] ^ t;
    for (int i = 1; i < 4; i++) begin
        w[i] = w[i] ^ w[i-1];
    end
    return {w[0], w[1], w[2], w[3]};
endfunction

function automatic logic [127:0] aes128_encrypt(input logic [127:0] key,
                                                input logic [127:0] pt);
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [127:0] rk;
    logic [127:0] ct;
    logic [7:0]   rcon;
    rk   = key;
    rcon = 8'h01;
    for (int i = 0; i < 16; i++) begin
        s[i] = pt[127-8*i -: 8] ^ key[127-8*i -: 8];
    end
    for (int r = 1; r <= 10; r++) begin
        rk   = next_round_key(rk, rcon);
        rcon = gf_mul(rcon, 8'h02);
        // Byte i is row i%4 of column i/4, and row n moves left by n columns.
        for (int i = 0; i < 16; i++) begin
            t[i] = sub_byte(s[(i + 4 * (i % 4)) % 16]);
        end
        for (int i = 0; i < 16; i++) begin
            if (r == 10) begin
                s[i] = t[i];
            end else begin
                s[i] = 8'h00;
                for (int k = 0; k < 4; k++) begin
                    s[i] = s[i] ^ gf_mul(t[4 * (i / 4) + k], mix_coef((k - i % 4 + 4) % 4));
                end
            end
            s[i] = s[i] ^ rk[127-8*i -: 8];
        end
    end
    for (int i = 0; i < 16; i++) begin
        ct[127-8*i -: 8] = s[i];
    end
    return ct;
endfunction

`endif

// ==== tb/aes_apb_tb.sv ====
// Testbench for the AES-128 APB core: known vector, random blocks, status and error responses.
`timescale 1ns/1ps

module aes_apb_tb
    import aes_types_pkg::*;
    import apb_regs_pkg::*;
();

    `include "aes_model.svh"

    // About 40 operations of 25 APB transfers and 21 round cycles each, with margin.
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int N_RANDOM       = 30;
    localparam aes_state_t FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_state_t FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_state_t FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic      clock;
    logic      arst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pslverr;
    logic      irq;
    int        seed;
    int        cycles;

    aes_apb_top UUT (
        .i_clock   (clock),
        .i_arst_n  (arst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pslverr (pslverr),
        .o_irq     (irq)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation stopped by the cycle limit.");
        end
    end

    // --------------------
    // Compare tasks.
    // --------------------
    task automatic check_state(input string name, input aes_state_t expected,
                               input aes_state_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in %s.", name);
        end
    endtask

    task automatic check_word(input string name, input apb_data_t expected,
                              input apb_data_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in %s.", name);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in %s.", name);
        end
    endtask

    // --------------------
    // APB transfers.
    // --------------------
    // Setup phase, access phase sampled at mid cycle, then one idle cycle.
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_flag("write response", 1'b0, err);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_flag("read response", 1'b0, err);
    endtask

    task automatic random_state(output aes_state_t s);
        s = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // Word 0 of each group carries bits 127 to 96.
    task automatic load_operands(input aes_state_t key, input aes_state_t pt);
        for (int i = 0; i < 4; i++) begin
            write_reg(apb_addr_t'(REG_KEY0 + 4 * i), key[127-32*i -: 32]);
            write_reg(apb_addr_t'(REG_DIN0 + 4 * i), pt[127-32*i -: 32]);
        end
    endtask

    task automatic read_result(output aes_state_t s);
        apb_data_t w;
        for (int i = 0; i < 4; i++) begin
            read_reg(apb_addr_t'(REG_DOUT0 + 4 * i), w);
            s[127-32*i -: 32] = w;
        end
    endtask

    // Poll STATUS until done, bounded by the cycle counter.
    task automatic wait_done();
        apb_data_t status;
        status = '0;
        while (status[1] == 1'b0) begin
            read_reg(REG_STATUS, status);
        end
        check_word("status at done", 32'h2, status);
        @(negedge clock);
        check_flag("irq at done", 1'b1, irq);
    endtask

    task automatic run_and_check(input string name, input aes_state_t key, input aes_state_t pt,
                                 input aes_state_t expected);
        aes_state_t result;
        load_operands(key, pt);
        write_reg(REG_CTRL, 32'h1);
        wait_done();
        read_result(result);
        check_state(name, expected, result);
    endtask

    initial begin
        aes_state_t key;
        aes_state_t pt;
        aes_state_t new_key;
        aes_state_t new_pt;
        aes_state_t result;
        apb_data_t  rdata;
        logic       err;

        seed    = 50;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        @(posedge clock);

        read_result(result);
        check_state("dout after reset", '0, result);

        // FIPS-197 appendix C.1, first against the model, then through the core.
        check_state("model known vector", FIPS_CT, aes128_encrypt(FIPS_KEY, FIPS_PT));
        run_and_check("known vector", FIPS_KEY, FIPS_PT, FIPS_CT);

        for (int n = 0; n < N_RANDOM; n++) begin
            random_state(key);
            random_state(pt);
            run_and_check("random block", key, pt, aes128_encrypt(key, pt));
        end

        // --------------------
        // Status and interrupt.
        // --------------------
        // Done is still set from the last run, so this start must clear it.
        random_state(key);
        random_state(pt);
        load_operands(key, pt);
        write_reg(REG_CTRL, 32'h1);
        read_reg(REG_STATUS, rdata);
        check_word("status after start", 32'h1, rdata);
        check_flag("irq after start", 1'b0, irq);
        wait_done();
        read_result(result);
        check_state("status run result", aes128_encrypt(key, pt), result);

        // Operand writes while busy.
        random_state(key);
        random_state(pt);
        load_operands(key, pt);
        write_reg(REG_CTRL, 32'h1);
        random_state(new_key);
        random_state(new_pt);
        write_reg(REG_DIN0, new_pt[127:96]);
        write_reg(REG_KEY0, new_key[127:96]);
        // Both writes above landed inside the busy window.
        read_reg(REG_STATUS, rdata);
        check_word("busy during rewrite", 32'h1, rdata);
        load_operands(new_key, new_pt);
        wait_done();
        read_result(result);
        check_state("result with captured operands", aes128_encrypt(key, pt), result);
        write_reg(REG_CTRL, 32'h1);
        wait_done();
        read_result(result);
        check_state("result with new operands", aes128_encrypt(new_key, new_pt), result);

        // --------------------
        // Error responses.
        // --------------------
        apb_transfer(1'b0, 8'h40, '0, rdata, err);
        check_flag("unmapped read", 1'b1, err);
        random_state(key);
        random_state(pt);
        load_operands(key, pt);
        write_reg(REG_CTRL, 32'h1);
        apb_transfer(1'b1, REG_CTRL, 32'h1, rdata, err);
        check_flag("start while busy", 1'b1, err);
        wait_done();
        read_result(result);
        check_state("result after rejected start", aes128_encrypt(key, pt), result);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== hw/aes_apb_top.sv ====
// AES APB top: connects the register block to the cipher engine.
`timescale 1ns/1ps

module aes_apb_top
    import aes_types_pkg::*;
    import apb_regs_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_arst_n,
    input  logic      i_psel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  apb_addr_t i_paddr,
    input  apb_data_t i_pwdata,
    output apb_data_t o_prdata,
    output logic      o_pslverr,
    output logic      o_irq
);

    logic       start;
    logic       busy;
    logic       done;
    aes_state_t key;
    aes_state_t block;
    aes_state_t result;

    // Host side.
    aes_apb_regs u_aes_apb_regs (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pslverr (o_pslverr),
        .o_irq     (o_irq),
        .o_start   (start),
        .o_key     (key),
        .o_block   (block),
        .i_busy    (busy),
        .i_done    (done),
        .i_result  (result)
    );

    // Cipher side.
    aes_cipher_engine u_aes_cipher_engine (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_start  (start),
        .i_key    (key),
        .i_block  (block),
        .o_busy   (busy),
        .o_done   (done),
        .o_result (result)
    );

endmodule

// ==== hw/aes_apb_regs.sv ====
// AES register block: APB slave with key, plaintext, control, status and result registers.
`timescale 1ns/1ps

module aes_apb_regs
    import aes_types_pkg::*;
    import apb_regs_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_psel,
    input  logic       i_penable,
    input  logic       i_pwrite,
    input  apb_addr_t  i_paddr,
    input  apb_data_t  i_pwdata,
    output apb_data_t  o_prdata,
    output logic       o_pslverr,
    output logic       o_irq,
    output logic       o_start,
    output aes_state_t o_key,
    output aes_state_t o_block,
    input  logic       i_busy,
    input  logic       i_done,
    input  aes_state_t i_result
);

    aes_state_t key_q;
    aes_state_t din_q;
    aes_state_t dout_q;
    logic       busy_q;
    logic       done_q;
    logic       access;
    logic       addr_err;
    logic       start_rejected;
    logic       wr_en;
    logic       start_wr;
    logic [1:0] idx;

    // Word 0 is the top word of the 128-bit register.
    function automatic apb_data_t word_of(input aes_state_t s, input logic [1:0] i);
        return s[(3 - i) * 32 +: 32];
    endfunction

    assign idx    = i_paddr[3:2];
    assign access = i_psel && i_penable;

    // --------------------
    // Read decode.
    // --------------------
    always_comb begin
        o_prdata = '0;
        addr_err = 1'b0;
        case (i_paddr)
            REG_CTRL:   o_prdata = '0;
            REG_STATUS: o_prdata = {30'd0, done_q, busy_q};
            REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3:     o_prdata = word_of(key_q, idx);
            REG_DIN0, REG_DIN1, REG_DIN2, REG_DIN3:     o_prdata = word_of(din_q, idx);
            REG_DOUT0, REG_DOUT1, REG_DOUT2, REG_DOUT3: o_prdata = word_of(dout_q, idx);
            default:    addr_err = 1'b1;
        endcase
    end

    // A start is refused while an operation runs.
    assign start_rejected = i_pwrite && (i_paddr == REG_CTRL) && i_pwdata[0] && i_busy;
    assign o_pslverr = access && (addr_err || start_rejected);
    assign wr_en     = access && i_pwrite && !o_pslverr;
    assign start_wr  = wr_en && (i_paddr == REG_CTRL) && i_pwdata[0];

    // Key and plaintext words.
    always_ff @(posedge i_clock) begin
        if (wr_en && i_paddr[7:4] == REG_KEY0[7:4]) begin
            key_q[(3 - idx) * 32 +: 32] <= i_pwdata;
        end
        if (wr_en && i_paddr[7:4] == REG_DIN0[7:4]) begin
            din_q[(3 - idx) * 32 +: 32] <= i_pwdata;
        end
    end

    // --------------------
    // Control and status.
    // --------------------
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_start <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            dout_q  <= '0;
        end else begin
            o_start <= start_wr;
            busy_q  <= i_busy;
            if (i_done) begin
                dout_q <= i_result;
            end
            // A new start wins over a finishing operation.
            if (start_wr) begin
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q <= 1'b1;
            end
        end
    end

    assign o_irq   = done_q;
    assign o_key   = key_q;
    assign o_block = din_q;

    a_penable_psel: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_penable |-> i_psel);

endmodule

// ==== hw/aes_cipher_engine.sv ====
// AES-128 cipher engine: iterates the round datapath with on-the-fly key expansion.
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_cipher_engine
    import aes_types_pkg::*;
    import apb_regs_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_start,
    input  aes_state_t i_key,
    input  aes_state_t i_block,
    output logic       o_busy,
    output logic       o_done,
    output aes_state_t o_result
);

    localparam int LUT = `AES_REG_LUT;

    engine_state_t state_q;
    aes_round_t    round_q;
    aes_state_t    data_q;
    aes_state_t    key_q;
    aes_state_t    round_out;
    aes_state_t    next_key;
    logic          last_round;
    logic          step;

    assign last_round = (round_q == aes_round_t'(`AES_N_ROUNDS));
    // The round result is ready in ROUND, or one cycle later with a registered S-box.
    assign step = (LUT == 0) ? (state_q == ROUND) : (state_q == WAIT_LUT);

    // --------------------
    // Datapath.
    // --------------------
    key_expansion_block u_key_expansion_block (
        .i_key   (key_q),
        .i_round (round_q),
        .o_key   (next_key)
    );

    round_block_sequential #(
        .CREATE_REG_LUT (LUT)
    ) u_round_block_sequential (
        .i_clock           (i_clock),
        .i_arst_n          (i_arst_n),
        .i_valid           (state_q == ROUND),
        .i_last_stage_flag (last_round),
        .i_state           (data_q),
        .i_round_key       (next_key),
        .o_state           (round_out)
    );

    // Initial AddRoundKey at start, then one round per step.
    always_ff @(posedge i_clock) begin
        if (state_q == IDLE && i_start) begin
            data_q <= i_block ^ i_key;
            key_q  <= i_key;
        end else if (step) begin
            data_q <= round_out;
            key_q  <= next_key;
        end
    end

    // --------------------
    // Round FSM.
    // --------------------
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            round_q <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= step && last_round;
            case (state_q)
                IDLE: begin
                    if (i_start) begin
                        state_q <= ROUND;
                        round_q <= 4'd1;
                    end
                end
                ROUND: begin
                    if (LUT != 0) begin
                        state_q <= WAIT_LUT;
                    end else if (last_round) begin
                        state_q <= IDLE;
                    end else begin
                        round_q <= round_q + 1'b1;
                    end
                end
                WAIT_LUT: begin
                    if (last_round) begin
                        state_q <= IDLE;
                    end else begin
                        state_q <= ROUND;
                        round_q <= round_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign o_busy   = (state_q != IDLE);
    assign o_result = data_q;

    // The register block must reject a start while an operation runs.
    a_no_start_busy: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_start |-> !o_busy);
    a_done_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_done |=> !o_done);
    a_round_range: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        round_q <= aes_round_t'(`AES_N_ROUNDS));

endmodule

// ==== hw/round_block_sequential.sv ====
// AES cipher round: SubBytes, ShiftRows, MixColumns (skipped last) and AddRoundKey.
`timescale 1ns/1ps
`include "aes_config.svh"

module round_block_sequential
    import aes_types_pkg::*;
#(
    parameter int CREATE_REG_LUT = 0
)
(
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_valid,
    input  logic       i_last_stage_flag,
    input  aes_state_t i_state,
    input  aes_state_t i_round_key,
    output aes_state_t o_state
);

    localparam int NB = `AES_NB_BYTE;
    localparam int W  = `AES_N_BYTES * `AES_NB_BYTE;

    aes_state_t state_a_subbytes;
    aes_state_t state_b_shiftrows;
    aes_state_t state_c_mixcolumns;

    // --------------------
    // SubBytes.
    // --------------------
    subbytes_block #(
        .CREATE_OUTPUT_REG (CREATE_REG_LUT)
    ) u_subbytes_block (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_state  (i_state),
        .o_state  (state_a_subbytes)
    );

    // ShiftRows, row r rotates left by r columns.
    for (genvar c = 0; c < 4; c++) begin : g_col
        for (genvar r = 0; r < 4; r++) begin : g_row
            assign state_b_shiftrows[W-1-NB*(4*c+r) -: NB] =
                state_a_subbytes[W-1-NB*(4*((c+r)%4)+r) -: NB];
        end
    end

    // --------------------
    // MixColumns.
    // --------------------
    mixcolumns_block u_mixcolumns_block (
        .i_state (state_b_shiftrows),
        .o_state (state_c_mixcolumns)
    );

    // Bypass on the final round, then add the key.
    assign o_state = (i_last_stage_flag ? state_b_shiftrows : state_c_mixcolumns)
                     ^ i_round_key;

endmodule

// ==== hw/key_expansion_block.sv ====
// AES-128 key schedule step: derives the next round key from the current one.
`timescale 1ns/1ps

module key_expansion_block
    import aes_types_pkg::*;
(
    input  aes_state_t i_key,
    input  aes_round_t i_round,
    output aes_state_t o_key
);

    aes_word_t w0;
    aes_word_t w1;
    aes_word_t w2;
    aes_word_t w3;
    aes_word_t rot_word;
    aes_word_t sub_word;
    aes_word_t temp;
    aes_byte_t rcon;

    assign {w0, w1, w2, w3} = i_key;

    // RotWord moves the top byte to the bottom.
    assign rot_word = {w3[23:0], w3[31:24]};

    // SubWord.
    for (genvar i = 0; i < 4; i++) begin : g_sbox
        aes_sbox u_aes_sbox (
            .i_byte (rot_word[8*i +: 8]),
            .o_byte (sub_word[8*i +: 8])
        );
    end

    // Round constant for the key being produced.
    always_comb begin
        case (i_round)
            4'd1:    rcon = 8'h01;
            4'd2:    rcon = 8'h02;
            4'd3:    rcon = 8'h04;
            4'd4:    rcon = 8'h08;
            4'd5:    rcon = 8'h10;
            4'd6:    rcon = 8'h20;
            4'd7:    rcon = 8'h40;
            4'd8:    rcon = 8'h80;
            4'd9:    rcon = 8'h1b;
            4'd10:   rcon = 8'h36;
            default: rcon = 8'h00;
        endcase
    end

    assign temp = sub_word ^ {rcon, 24'h000000};

    // Chained XOR, each word builds on the one before.
    assign o_key[127:96] = w0 ^ temp;
    assign o_key[95:64]  = w1 ^ o_key[127:96];
    assign o_key[63:32]  = w2 ^ o_key[95:64];
    assign o_key[31:0]   = w3 ^ o_key[63:32];

endmodule

// ==== hw/mixcolumns_block.sv ====
// AES MixColumns: multiplies each state column by the fixed matrix in GF(2^8).
`timescale 1ns/1ps
`include "aes_config.svh"

module mixcolumns_block
    import aes_types_pkg::*;
(
    input  aes_state_t i_state,
    output aes_state_t o_state
);

    localparam int NB = `AES_NB_BYTE;
    localparam int W  = `AES_N_BYTES * `AES_NB_BYTE;

    // Doubling modulo x^8 + x^4 + x^3 + x + 1.
    function automatic aes_byte_t xtime(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Times three is doubling plus the byte itself.
    function automatic aes_byte_t mul3(input aes_byte_t b);
        return xtime(b) ^ b;
    endfunction

    always_comb begin
        aes_byte_t a [4];
        for (int c = 0; c < 4; c++) begin
            // Rows of column c.
            for (int r = 0; r < 4; r++) begin
                a[r] = i_state[W-1-NB*(4*c+r) -: NB];
            end
            // Circulant matrix rows {2 3 1 1}.
            o_state[W-1-NB*(4*c)   -: NB] = xtime(a[0]) ^ mul3(a[1]) ^ a[2] ^ a[3];
            o_state[W-1-NB*(4*c+1) -: NB] = a[0] ^ xtime(a[1]) ^ mul3(a[2]) ^ a[3];
            o_state[W-1-NB*(4*c+2) -: NB] = a[0] ^ a[1] ^ xtime(a[2]) ^ mul3(a[3]);
            o_state[W-1-NB*(4*c+3) -: NB] = mul3(a[0]) ^ a[1] ^ a[2] ^ xtime(a[3]);
        end
    end

endmodule

// ==== hw/subbytes_block.sv ====
// AES SubBytes: sixteen parallel S-box lookups, optionally registered.
`timescale 1ns/1ps
`include "aes_config.svh"

module subbytes_block
    import aes_types_pkg::*;
#(
    parameter int CREATE_OUTPUT_REG = 0
)
(
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_valid,
    input  aes_state_t i_state,
    output aes_state_t o_state
);

    localparam int NB = `AES_NB_BYTE;
    localparam int W  = `AES_N_BYTES * `AES_NB_BYTE;

    aes_state_t sub_comb;

    // One lookup per state byte.
    for (genvar i = 0; i < `AES_N_BYTES; i++) begin : g_sbox
        aes_sbox u_aes_sbox (
            .i_byte (i_state[W-1-NB*i -: NB]),
            .o_byte (sub_comb[W-1-NB*i -: NB])
        );
    end

    if (CREATE_OUTPUT_REG != 0) begin : g_out_reg
        aes_state_t state_q;

        // Capture when the engine strobes the first half of a round.
        always_ff @(posedge i_clock) begin
            if (i_valid) begin
                state_q <= sub_comb;
            end
        end
        assign o_state = state_q;
    end else begin : g_no_reg
        assign o_state = sub_comb;
    end

    // Only the registered and the combinational variant exist.
    a_param_legal: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        CREATE_OUTPUT_REG inside {0, 1});

endmodule

// ==== hw/aes_sbox.sv ====
// AES forward S-box: substitutes one byte through the 256-entry table.
`timescale 1ns/1ps

module aes_sbox
    import aes_types_pkg::*;
(
    input  aes_byte_t i_byte,
    output aes_byte_t o_byte
);

    // Table rows of sixteen entries.
    // Entry 0 is in the top byte.
    localparam logic [2047:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Entry n lives at bit offset (255 - n) * 8.
    assign o_byte = SBOX_TABLE[(255 - i_byte) * 8 +: 8];

endmodule

// ==== hw/apb_regs_pkg.sv ====
// Register interface types: APB address and data, register map and engine states.
package apb_regs_pkg;

    `include "aes_config.svh"

    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [31:0]            apb_data_t;

    // --------------------
    // Register map.
    // --------------------
    // Word 0 of each group holds bits 127 to 96.
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_STATUS = 8'h04;
    localparam apb_addr_t REG_KEY0   = 8'h10;
    localparam apb_addr_t REG_KEY1   = 8'h14;
    localparam apb_addr_t REG_KEY2   = 8'h18;
    localparam apb_addr_t REG_KEY3   = 8'h1C;
    localparam apb_addr_t REG_DIN0   = 8'h20;
    localparam apb_addr_t REG_DIN1   = 8'h24;
    localparam apb_addr_t REG_DIN2   = 8'h28;
    localparam apb_addr_t REG_DIN3   = 8'h2C;
    localparam apb_addr_t REG_DOUT0  = 8'h30;
    localparam apb_addr_t REG_DOUT1  = 8'h34;
    localparam apb_addr_t REG_DOUT2  = 8'h38;
    localparam apb_addr_t REG_DOUT3  = 8'h3C;

    // Cipher engine FSM states.
    typedef enum logic [1:0] {IDLE, ROUND, WAIT_LUT} engine_state_t;

endpackage

// ==== hw/aes_types_pkg.sv ====
// AES data types: bytes, column words, the 128-bit state and the round index.
package aes_types_pkg;

    `include "aes_config.svh"

    // One state byte.
    typedef logic [`AES_NB_BYTE-1:0] aes_byte_t;

    // One column of four bytes, also one key word.
    typedef logic [4*`AES_NB_BYTE-1:0] aes_word_t;

    // Full state, key or block.
    // Byte 0 sits in the top eight bits, as in FIPS-197.
    typedef logic [`AES_N_BYTES*`AES_NB_BYTE-1:0] aes_state_t;

    // Round index, 0 to AES_N_ROUNDS.
    typedef logic [3:0] aes_round_t;

endpackage

// ==== hw/aes_config.svh ====
// AES core configuration: data widths, round count, S-box register option and APB address width.
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// --------------------
// Cipher geometry.
// --------------------
// Bits per state byte.
`define AES_NB_BYTE 8
// Bytes in the state, the key and the block.
`define AES_N_BYTES 16
// Rounds for a 128-bit key.
`define AES_N_ROUNDS 10

// Register the S-box outputs when set to 1.
// Each round then takes two cycles.
`define AES_REG_LUT 0

// --------------------
// Host bus.
// --------------------
`define APB_ADDR_W 8

`endif
